/* Makefile */
# Verilator build and run of the AC monitor testbench

SRC := list.f $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vspi_ac_monitor_tb: $(SRC)
	verilator --binary --timing --assert -f list.f --top-module spi_ac_monitor_tb

run: obj_dir/Vspi_ac_monitor_tb
	./obj_dir/Vspi_ac_monitor_tb 2>&1 | tee sim.log
	@if grep -q "Result: FAILED" sim.log || ! grep -q "Result: PASSED" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* list.f */
+incdir+source
source/spi_timing_pkg.sv
source/pin_sampler.sv
source/timing_checker.sv
source/limit_regs.sv
source/spi_ac_monitor.sv
verification/spi_ac_monitor_asserts.sv
verification/spi_ac_monitor_tb.sv

/* source/limit_regs.sv */
// ----------------------------------------
// Monitor configuration registers
// Minimum limits and sticky violation status
// ----------------------------------------
`timescale 1ns/1ps
`include "spi_timing_settings.svh"

module limit_regs
(
   input  logic                       c,
   input  logic                       rst_n,
   input  logic                       cfg_we,
   input  spi_timing_pkg::cfg_addr_t  cfg_addr,
   input  spi_timing_pkg::cycle_cnt_t cfg_wdata,
   input  logic                       clr,
   input  spi_timing_pkg::viol_t      viol,
   output spi_timing_pkg::limits_t    lim,
   output spi_timing_pkg::viol_t      status
);
   import spi_timing_pkg::*;

   localparam limits_t LIM_DEFAULT = '{
      shsl: cycle_cnt_t'(`SPI_DEF_SHSL),
      slch: cycle_cnt_t'(`SPI_DEF_SLCH),
      chsh: cycle_cnt_t'(`SPI_DEF_CHSH),
      dvch: cycle_cnt_t'(`SPI_DEF_DVCH),
      chdx: cycle_cnt_t'(`SPI_DEF_CHDX),
      ch:   cycle_cnt_t'(`SPI_DEF_CH),
      cl:   cycle_cnt_t'(`SPI_DEF_CL),
      tc:   cycle_cnt_t'(`SPI_DEF_TC),
      tr:   cycle_cnt_t'(`SPI_DEF_TR)
   };

   limits_t lim_q;
   viol_t   status_q;

   // Limit writes by address 0 to 8 in field order
   always_ff @(posedge c)
   begin
      if (!rst_n)
         lim_q <= LIM_DEFAULT;
      else if (cfg_we)
      begin
         case (cfg_addr)
            0: lim_q.shsl <= cfg_wdata;
            1: lim_q.slch <= cfg_wdata;
            2: lim_q.chsh <= cfg_wdata;
            3: lim_q.dvch <= cfg_wdata;
            4: lim_q.chdx <= cfg_wdata;
            5: lim_q.ch <= cfg_wdata;
            6: lim_q.cl <= cfg_wdata;
            7: lim_q.tc <= cfg_wdata;
            8: lim_q.tr <= cfg_wdata;
            default: ;
         endcase
      end
   end

   // Sticky status where a pulse in the clear cycle still lands
   always_ff @(posedge c)
   begin
      if (!rst_n)
         status_q <= '0;
      else
         status_q <= (clr ? viol_t'(0) : status_q) | viol;
   end

   assign lim = lim_q;
   assign status = status_q;

endmodule

/* source/pin_sampler.sv */
// ----------------------------------------
// Bus pin sampler
// Synchronizes sck, cs_n, d and read_op
// and flags their edges one flop later
// ----------------------------------------
`timescale 1ns/1ps

module pin_sampler
(
   input  logic                       c,
   input  logic                       rst_n,
   input  logic                       sck,
   input  logic                       cs_n,
   input  logic                       d,
   input  logic                       read_op,
   output spi_timing_pkg::pin_event_t ev
);
   import spi_timing_pkg::*;

   // Bus at rest in bit order {read_op, d, cs_n, sck}
   localparam logic [3:0] PINS_IDLE = 4'b0010;
   localparam pin_event_t EV_IDLE = '{cs_n: 1'b1, default: 1'b0};

   logic [3:0] sync1;
   logic [3:0] sync2;
   pin_event_t ev_d;
   pin_event_t ev_q;

   // Two-flop synchronizers
   always_ff @(posedge c)
   begin
      if (!rst_n)
      begin
         sync1 <= PINS_IDLE;
         sync2 <= PINS_IDLE;
      end
      else
      begin
         sync1 <= {read_op, d, cs_n, sck};
         sync2 <= sync1;
      end
   end

   // Levels in ev_q are the delayed copy the edges are taken against
   always_comb
   begin
      ev_d.sck = sync2[0];
      ev_d.cs_n = sync2[1];
      ev_d.d = sync2[2];
      ev_d.read_op = sync2[3];
      ev_d.sck_rise = sync2[0] & ~ev_q.sck;
      ev_d.sck_fall = ~sync2[0] & ev_q.sck;
      ev_d.cs_fall = ~sync2[1] & ev_q.cs_n;
      ev_d.cs_rise = sync2[1] & ~ev_q.cs_n;
      ev_d.d_chg = sync2[2] ^ ev_q.d;
   end

   always_ff @(posedge c)
   begin
      if (!rst_n)
         ev_q <= EV_IDLE;
      else
         ev_q <= ev_d;
   end

   assign ev = ev_q;

endmodule

/* source/spi_ac_monitor.sv */
// ----------------------------------------
// Serial flash AC timing monitor
// Sampler, checker and register block
// ----------------------------------------
`timescale 1ns/1ps

module spi_ac_monitor
(
   input  logic                       c,
   input  logic                       rst_n,
   input  logic                       sck,
   input  logic                       cs_n,
   input  logic                       d,
   input  logic                       read_op,
   input  logic                       cfg_we,
   input  spi_timing_pkg::cfg_addr_t  cfg_addr,
   input  spi_timing_pkg::cycle_cnt_t cfg_wdata,
   input  logic                       clr,
   output spi_timing_pkg::viol_t      viol,
   output spi_timing_pkg::viol_t      status
);
   import spi_timing_pkg::*;

   pin_event_t ev;
   limits_t    lim;

   pin_sampler u_sampler
   (
      .c       (c),
      .rst_n   (rst_n),
      .sck     (sck),
      .cs_n    (cs_n),
      .d       (d),
      .read_op (read_op),
      .ev      (ev)
   );

   timing_checker u_checker
   (
      .c     (c),
      .rst_n (rst_n),
      .ev    (ev),
      .lim   (lim),
      .viol  (viol)
   );

   limit_regs u_regs
   (
      .c         (c),
      .rst_n     (rst_n),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .clr       (clr),
      .viol      (viol),
      .lim       (lim),
      .status    (status)
   );

endmodule

/* source/spi_timing_pkg.sv */
// ----------------------------------------
// Serial flash AC monitor types
// Counts, limits, pin events and FSM states
// ----------------------------------------
`include "spi_timing_settings.svh"

package spi_timing_pkg;

   typedef logic [`SPI_CNT_W-1:0] cycle_cnt_t;
   typedef logic [`SPI_CFG_AW-1:0] cfg_addr_t;

   // One bit per check
   typedef logic [7:0] viol_t;

   localparam int V_SHSL = 0;
   localparam int V_SLCH = 1;
   localparam int V_CHSH = 2;
   localparam int V_DVCH = 3;
   localparam int V_CHDX = 4;
   localparam int V_CH = 5;
   localparam int V_CL = 6;
   localparam int V_PERIOD = 7;

   // Field order is also the register address order
   typedef struct packed {
      cycle_cnt_t shsl;
      cycle_cnt_t slch;
      cycle_cnt_t chsh;
      cycle_cnt_t dvch;
      cycle_cnt_t chdx;
      cycle_cnt_t ch;
      cycle_cnt_t cl;
      cycle_cnt_t tc;
      cycle_cnt_t tr;
   } limits_t;

   typedef struct packed {
      logic sck;
      logic cs_n;
      logic d;
      logic read_op;
      logic sck_rise;
      logic sck_fall;
      logic cs_fall;
      logic cs_rise;
      logic d_chg;
   } pin_event_t;

   typedef enum logic [1:0] {
      DESELECTED,
      WAIT_FIRST_RISE,
      SELECTED
   } sel_state_t;

endpackage

/* source/spi_timing_settings.svh */
// ----------------------------------------
// Serial flash AC monitor settings
// Count widths and default minimum limits
// ----------------------------------------
`ifndef SPI_TIMING_SETTINGS_SVH
`define SPI_TIMING_SETTINGS_SVH

// Interval counters and limits in cycles of c
`define SPI_CNT_W 8

// Configuration register address width
`define SPI_CFG_AW 4

// Default minimum intervals in cycles
`define SPI_DEF_SHSL 10
`define SPI_DEF_SLCH 3
`define SPI_DEF_CHSH 3
`define SPI_DEF_DVCH 2
`define SPI_DEF_CHDX 2
`define SPI_DEF_CH 4
`define SPI_DEF_CL 4
`define SPI_DEF_TC 10
`define SPI_DEF_TR 14

`endif

/* source/timing_checker.sv */
// ----------------------------------------
// AC timing checker
// Measures pin event intervals in cycles
// and flags those below their minimum
// ----------------------------------------
`timescale 1ns/1ps

module timing_checker
(
   input  logic                       c,
   input  logic                       rst_n,
   input  spi_timing_pkg::pin_event_t ev,
   input  spi_timing_pkg::limits_t    lim,
   output spi_timing_pkg::viol_t      viol
);
   import spi_timing_pkg::*;

   // Interval counter slots
   localparam int N_CNT = 5;
   localparam int K_RISE = 0;
   localparam int K_FALL = 1;
   localparam int K_CSR = 2;
   localparam int K_CSF = 3;
   localparam int K_D = 4;

   localparam cycle_cnt_t CNT_MAX = '1;

   cycle_cnt_t       cnt [N_CNT];
   logic [N_CNT-1:0] restart;
   sel_state_t       state;
   sel_state_t       state_nx;
   logic             d_low_chg;
   logic             first_rise;
   logic             selected;
   cycle_cnt_t       period_lim;
   viol_t            viol_nx;
   viol_t            viol_q;

   // ----------------------------------------
   // Cycles since each pin event
   // ----------------------------------------
   assign restart = {ev.d_chg, ev.cs_fall, ev.cs_rise, ev.sck_fall, ev.sck_rise};

   // Saturate so a long idle never wraps into a short interval
   always_ff @(posedge c)
   begin
      for (int i = 0; i < N_CNT; i++)
      begin
         if (!rst_n)
            cnt[i] <= CNT_MAX;
         else if (restart[i])
            cnt[i] <= cycle_cnt_t'(1);
         else if (cnt[i] != CNT_MAX)
            cnt[i] <= cnt[i] + cycle_cnt_t'(1);
      end
   end

   // ----------------------------------------
   // Select phase FSM
   // ----------------------------------------
   always_comb
   begin
      state_nx = state;
      if (ev.cs_rise)
         state_nx = DESELECTED;
      else if (ev.cs_fall)
         state_nx = WAIT_FIRST_RISE;
      else if (ev.sck_rise && state == WAIT_FIRST_RISE)
         state_nx = SELECTED;
   end

   always_ff @(posedge c)
   begin
      if (!rst_n)
         state <= DESELECTED;
      else
         state <= state_nx;
   end

   // Data moved during the current clock low phase
   always_ff @(posedge c)
   begin
      if (!rst_n)
         d_low_chg <= 1'b0;
      else if (ev.sck_rise || ev.cs_rise)
         d_low_chg <= 1'b0;
      else if (ev.d_chg && !ev.sck && !ev.cs_n)
         d_low_chg <= 1'b1;
   end

   // ----------------------------------------
   // Minimum interval checks
   // ----------------------------------------
   assign first_rise = ev.sck_rise && (state == WAIT_FIRST_RISE);
   assign selected = (state == SELECTED);
   assign period_lim = ev.read_op ? lim.tr : lim.tc;

   always_comb
   begin
      viol_nx[V_SHSL] = ev.cs_fall && (cnt[K_CSR] < lim.shsl);
      // First rise measures select setup and later rises the clock period
      viol_nx[V_SLCH] = first_rise && (cnt[K_CSF] < lim.slch);
      viol_nx[V_CHSH] = ev.cs_rise && selected && (cnt[K_RISE] < lim.chsh);
      viol_nx[V_DVCH] = ev.sck_rise && d_low_chg && (cnt[K_D] < lim.dvch);
      viol_nx[V_CHDX] = ev.d_chg && ev.sck && !ev.cs_n && (cnt[K_RISE] < lim.chdx);
      viol_nx[V_CH] = ev.sck_fall && selected && (cnt[K_RISE] < lim.ch);
      viol_nx[V_CL] = ev.sck_rise && selected && (cnt[K_FALL] < lim.cl);
      viol_nx[V_PERIOD] = ev.sck_rise && selected && (cnt[K_RISE] < period_lim);
   end

   // One-cycle pulses a cycle after the closing event
   always_ff @(posedge c)
   begin
      if (!rst_n)
         viol_q <= '0;
      else
         viol_q <= viol_nx;
   end

   assign viol = viol_q;

endmodule

/* verification/spi_ac_monitor_asserts.sv */
// ----------------------------------------
// Monitor output assertions
// Reset values and sticky status behavior
// ----------------------------------------
`timescale 1ns/1ps

module spi_ac_monitor_asserts
(
   input logic                  c,
   input logic                  rst_n,
   input logic                  clr,
   input spi_timing_pkg::viol_t viol,
   input spi_timing_pkg::viol_t status
);

   // Outputs come out of reset cleared
   reset_clear: assert property (@(posedge c)
      !rst_n |=> (viol == '0 && status == '0))
      else $error("viol or status not zero after reset");

   // Each pulse lands in the sticky status
   pulse_sticks: assert property (@(posedge c)
      (rst_n && viol != '0) |=> ((status & $past(viol)) == $past(viol)))
      else $error("viol pulse missing from status");

   // Status only drops on clr or reset
   status_holds: assert property (@(posedge c)
      (rst_n && !clr) |=> ((status & $past(status)) == $past(status)))
      else $error("status bit fell without clr");

endmodule

bind spi_ac_monitor spi_ac_monitor_asserts u_asserts
(
   .c      (c),
   .rst_n  (rst_n),
   .clr    (clr),
   .viol   (viol),
   .status (status)
);

/* verification/spi_ac_monitor_tb.sv */
// ----------------------------------------
// Serial flash AC monitor testbench
// Replays a table of transfers as pin
// waveforms and checks status and pulses
// ----------------------------------------
`timescale 1ns/1ps
`include "spi_timing_settings.svh"

module spi_ac_monitor_tb;
   import spi_timing_pkg::*;

   localparam int RESET_ROW = 13;

   // One transfer with all times in cycles of c
   typedef struct packed {
      int gap;
      int setup;
      int high;
      int low;
      int dsu;
      int dho;
      int dh;
      int rd;
      int np;
      int ov_addr;
      int ov_val;
   } row_t;

   logic       c;
   logic       rst_n;
   logic       sck;
   logic       cs_n;
   logic       d;
   logic       read_op;
   logic       cfg_we;
   cfg_addr_t  cfg_addr;
   cycle_cnt_t cfg_wdata;
   logic       clr;
   viol_t      viol;
   viol_t      status;

   row_t        rows[$];
   int          lim_m[9];
   int          bit_cnt[8];
   logic [31:0] lfsr;
   int          errors = 0;
   int          cycles = 0;
   int          limit = 0;

   spi_ac_monitor UUT
   (
      .c         (c),
      .rst_n     (rst_n),
      .sck       (sck),
      .cs_n      (cs_n),
      .d         (d),
      .read_op   (read_op),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .clr       (clr),
      .viol      (viol),
      .status    (status)
   );

   initial
   begin
      c = 1'b0;
      forever #5 c = ~c;
   end

   always @(posedge c)
   begin
      cycles = cycles + 1;
      if (limit > 0 && cycles >= limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   // Running pulse count per check bit
   always @(negedge c)
   begin
      for (int i = 0; i < 8; i++)
      begin
         if (!rst_n)
            bit_cnt[i] = 0;
         else if (viol[i])
            bit_cnt[i] = bit_cnt[i] + 1;
      end
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge c);
      #1;
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      wait_cycles(8);
      rst_n = 1'b1;
      lim_m = '{`SPI_DEF_SHSL, `SPI_DEF_SLCH, `SPI_DEF_CHSH, `SPI_DEF_DVCH, `SPI_DEF_CHDX,
                `SPI_DEF_CH, `SPI_DEF_CL, `SPI_DEF_TC, `SPI_DEF_TR};
   endtask

   // Galois LFSR stepped once per bit taken
   function automatic int lfsr_bits(input int n);
      int   v;
      logic b;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         b = lfsr[0];
         lfsr = lfsr >> 1;
         if (b)
            lfsr = lfsr ^ 32'h8020_0003;
         v = (v << 1) | int'(b);
      end
      return v;
   endfunction

   function automatic void add_row(input int gap, input int setup, input int high,
                                   input int low, input int dsu, input int dho, input int dh,
                                   input int rd, input int np, input int ov_addr,
                                   input int ov_val);
      row_t r;
      r = '{gap, setup, high, low, dsu, dho, dh, rd, np, ov_addr, ov_val};
      rows.push_back(r);
   endfunction

   function automatic void add_check(input bit hit, input int b, input int times,
                                     inout logic [7:0] m, inout int n);
      if (hit && times > 0)
      begin
         m[b] = 1'b1;
         n = n + times;
      end
   endfunction

   // A check fires when its interval is shorter than its limit
   function automatic void predict(input row_t r, output logic [7:0] m, output int n);
      m = '0;
      n = 0;
      add_check(r.gap < lim_m[0], V_SHSL, 1, m, n);
      add_check(r.setup < lim_m[1], V_SLCH, 1, m, n);
      add_check(r.dh < lim_m[2], V_CHSH, 1, m, n);
      // Only the rises after the first have a data change in the low phase
      add_check(r.dsu < lim_m[3], V_DVCH, r.np - 1, m, n);
      add_check(r.dho < lim_m[4], V_CHDX, r.np - 1, m, n);
      add_check(r.high < lim_m[5], V_CH, r.np - 1, m, n);
      add_check(r.low < lim_m[6], V_CL, r.np - 1, m, n);
      add_check(r.high + r.low < (r.rd != 0 ? lim_m[8] : lim_m[7]), V_PERIOD, r.np - 1, m, n);
   endfunction

   task automatic run_row(input int idx, input row_t r);
      logic [7:0] exp_m;
      logic [7:0] seen;
      int         exp_n;
      int         n;
      int         err0;
      int         base[8];
      err0 = errors;
      cfg_we = 1'b1;
      cfg_addr = cfg_addr_t'(r.ov_addr);
      cfg_wdata = cycle_cnt_t'(r.ov_val);
      wait_cycles(1);
      cfg_we = 1'b0;
      if (r.ov_addr < 9)
         lim_m[r.ov_addr] = r.ov_val;
      predict(r, exp_m, exp_n);
      base = bit_cnt;
      read_op = r.rd[0];
      wait_cycles(16);
      // Short select with no clock opens the deselect gap
      cs_n = 1'b0;
      wait_cycles(2);
      cs_n = 1'b1;
      wait_cycles(r.gap);
      cs_n = 1'b0;
      wait_cycles(r.setup);
      sck = 1'b1;
      for (int p = 1; p < r.np; p++)
      begin
         wait_cycles(r.dho);
         d = ~d;
         wait_cycles(r.high - r.dho);
         sck = 1'b0;
         wait_cycles(r.low - r.dsu);
         d = ~d;
         wait_cycles(r.dsu);
         sck = 1'b1;
      end
      wait_cycles(r.dh);
      cs_n = 1'b1;
      wait_cycles(1);
      sck = 1'b0;
      wait_cycles(8);
      n = 0;
      for (int i = 0; i < 8; i++)
      begin
         seen[i] = (bit_cnt[i] != base[i]);
         n = n + bit_cnt[i] - base[i];
      end
      if (status != exp_m)
      begin
         $display("ERROR at %0t: row %0d status %b, expected %b", $time, idx, status, exp_m);
         errors = errors + 1;
      end
      if (seen != exp_m || n != exp_n)
      begin
         $display("ERROR at %0t: row %0d pulses %0d on %b, expected %0d on %b",
                  $time, idx, n, seen, exp_n, exp_m);
         errors = errors + 1;
      end
      clr = 1'b1;
      wait_cycles(1);
      clr = 1'b0;
      if (status != '0)
      begin
         $display("ERROR at %0t: row %0d status %b after clr", $time, idx, status);
         errors = errors + 1;
      end
      $display("Row %0d: mask %b, %0d pulses, %s", idx, exp_m, exp_n,
               (errors == err0) ? "ok" : "mismatch");
   endtask

   initial
   begin
      row_t rr;
      rst_n = 1'b0;
      sck = 1'b0;
      cs_n = 1'b1;
      d = 1'b0;
      read_op = 1'b0;
      cfg_we = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;
      clr = 1'b0;
      lfsr = 32'h5072_9426;

      //      gap set  hi  lo dsu dho  dh  rd  np addr val
      add_row(12,  4,  5,  5,  2,  2,  4,  0,  3, 15,  0);
      add_row( 9,  4,  5,  5,  2,  2,  4,  0,  3, 15,  0);
      add_row(12,  2,  5,  5,  2,  2,  4,  0,  3, 15,  0);
      add_row(12,  4,  5,  5,  2,  2,  2,  0,  3, 15,  0);
      add_row(12,  4,  5,  5,  1,  2,  4,  0,  3, 15,  0);
      add_row(12,  4,  5,  5,  2,  1,  4,  0,  3, 15,  0);
      add_row(12,  4,  3,  7,  2,  2,  4,  0,  3, 15,  0);
      add_row(12,  4,  7,  3,  2,  2,  4,  0,  3, 15,  0);
      add_row(12,  4,  4,  5,  2,  2,  4,  0,  3, 15,  0);
      // Period between tC and tR for a read and then a non-read
      add_row(12,  4,  6,  6,  2,  2,  4,  1,  3, 15,  0);
      add_row(12,  4,  6,  6,  2,  2,  4,  0,  3, 15,  0);
      // tCH raised and then lowered
      add_row(12,  4,  5,  5,  2,  2,  4,  0,  3,  5,  8);
      add_row(12,  4,  3,  7,  2,  2,  4,  0,  3,  5,  3);
      add_row(12,  4,  3,  7,  2,  2,  4,  0,  3, 15,  0);

      for (int k = 0; k < 12; k++)
      begin
         rr.gap = lfsr_bits(4) + 1;
         rr.setup = lfsr_bits(4) + 1;
         rr.high = lfsr_bits(4) + 1;
         rr.low = lfsr_bits(4) + 1;
         rr.dsu = lfsr_bits(4) + 1;
         rr.dho = lfsr_bits(4) + 1;
         rr.dh = lfsr_bits(4) + 1;
         rr.rd = lfsr_bits(1);
         rr.np = lfsr_bits(2) + 1;
         rr.ov_addr = 15;
         rr.ov_val = 0;
         // Data edges stay inside their clock phase
         if (rr.dsu >= rr.low)
            rr.low = rr.dsu + 1;
         if (rr.dho >= rr.high)
            rr.high = rr.dho + 1;
         rows.push_back(rr);
      end

      limit = rows.size() * 200 + 100;
      apply_reset();
      for (int i = 0; i < rows.size(); i++)
      begin
         if (i == RESET_ROW)
         begin
            apply_reset();
            // Select pulse right after reset before any full deselect interval
            cs_n = 1'b0;
            wait_cycles(2);
            cs_n = 1'b1;
         end
         run_row(i, rows[i]);
      end

      $display("Rows run: %0d, errors: %0d", rows.size(), errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule
